// ==== verilog.f ====
+incdir+design
design/cpu_pkg.sv
design/cpu_ctrl_if.sv
design/cpu_control.sv
design/cpu_fetch.sv
design/cpu_regfile.sv
design/cpu_execute.sv
design/cpu_writeback.sv
design/cpu_top.sv
dv/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f verilog.f \
    -o cpu_tb_sim > build.log 2>&1 &&
./obj_dir/cpu_tb_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// ==== dv/cpu_tb.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb;

    localparam logic [`XLEN-1:0] NOP_WORD = {`OP_NOP, 11'd0};

    logic               clk_50MHz;
    logic               rst;
    logic [`XLEN-1:0]   inst_addr_o;
    logic [`XLEN-1:0]   inst_i;
    logic [`XLEN-1:0]   mem_addr_o;
    logic [`XLEN-1:0]   mem_wdata_o;
    logic               mem_we_o;
    logic               mem_re_o;
    logic [`XLEN-1:0]   mem_rdata_i;
    logic               wb_en_o;
    logic [`REG_AW-1:0] wb_addr_o;
    logic [`XLEN-1:0]   wb_data_o;

    logic [`XLEN-1:0]   imem [256];
    logic [`XLEN-1:0]   dmem [256];
    logic [`XLEN-1:0]   prog [$];
    // expected streams as {addr, data}
    logic [18:0]        exp_wb [$];
    logic [31:0]        exp_st [$];
    logic [18:0]        wb_exp;
    logic [31:0]        st_exp;
    string              test_name;
    int                 errors;
    int                 checks;
    int                 since_rst;
    bit                 timed_out;

    cpu_top dut
    (
        .clk_50MHz_i (clk_50MHz),
        .rst_i       (rst),
        .inst_addr_o (inst_addr_o),
        .inst_i      (inst_i),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_we_o    (mem_we_o),
        .mem_re_o    (mem_re_o),
        .mem_rdata_i (mem_rdata_i),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

    initial
    begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    // ******************************
    // encoding helpers
    // ******************************
    function automatic logic [15:0] rr_word(input logic [4:0] op, input logic [2:0] rx,
                                            input logic [2:0] ry, input logic [2:0] rz,
                                            input logic [1:0] fn);
        return {op, rx, ry, rz, fn};
    endfunction

    function automatic logic [15:0] imm_word(input logic [4:0] op, input logic [2:0] rx,
                                             input logic [7:0] imm);
        return {op, rx, imm};
    endfunction

    // every data word differs and exposes a wrong address
    function automatic logic [15:0] fill_word(input logic [7:0] a);
        return {a ^ 8'h3c, ~a};
    endfunction

    // ******************************
    // reference model
    // ******************************
    // architectural run that returns the dynamic instruction count
    function automatic int run_model();
        logic [15:0] regs [8];
        logic [15:0] mem [256];
        logic [15:0] pc;
        logic [15:0] next_pc;
        logic [15:0] w;
        logic [15:0] sx;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [2:0]  dst;
        logic        wr;
        int          steps;
        for (int r = 0; r < 8; r++)
            regs[r] = '0;
        for (int k = 0; k < 256; k++)
            mem[k] = fill_word(8'(k));
        exp_wb.delete();
        exp_st.delete();
        pc    = '0;
        steps = 0;
        while (steps < 2000)
        begin
            w = imem[pc[7:0]];
            steps++;
            // B to itself ends the program
            if (w[15:11] == `OP_B && w[7:0] == 8'hff)
                break;
            sx      = {{8{w[7]}}, w[7:0]};
            a       = regs[w[10:8]];
            b       = regs[w[7:5]];
            next_pc = pc + 16'd1;
            wr      = 1'b0;
            dst     = w[10:8];
            res     = '0;
            case (w[15:11])
                `OP_LI:
                begin
                    wr  = 1'b1;
                    res = {8'h00, w[7:0]};
                end
                `OP_ADDIU:
                begin
                    wr  = 1'b1;
                    res = a + sx;
                end
                `OP_RR:
                begin
                    wr  = 1'b1;
                    dst = w[4:2];
                    case (w[1:0])
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        default:  res = a | b;
                    endcase
                end
                `OP_LW:
                begin
                    wr  = 1'b1;
                    res = mem[b[7:0]];
                end
                `OP_SW:
                begin
                    mem[b[7:0]] = a;
                    exp_st.push_back({b, a});
                end
                `OP_BEQZ: if (a == 16'd0) next_pc = pc + 16'd1 + sx;
                `OP_B:    next_pc = pc + 16'd1 + sx;
                default: ;
            endcase
            if (wr)
            begin
                regs[dst] = res;
                exp_wb.push_back({dst, res});
            end
            pc = next_pc;
        end
        return steps;
    endfunction

    // ******************************
    // memories
    // ******************************
    always @(posedge clk_50MHz)
    begin
        if (!rst)
        begin
            for (int k = 0; k < 256; k++)
                dmem[k] <= fill_word(8'(k));
        end
        else if (mem_we_o)
            dmem[mem_addr_o[7:0]] <= mem_wdata_o;
    end

    // read data goes out on the falling edge
    always @(negedge clk_50MHz)
    begin
        inst_i      = imem[inst_addr_o[7:0]];
        mem_rdata_i = dmem[mem_addr_o[7:0]];
    end

    always @(posedge clk_50MHz)
    begin
        if (!rst)
            since_rst <= 0;
        else if (since_rst < 100)
            since_rst <= since_rst + 1;
    end

    // ******************************
    // scoreboard
    // ******************************
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    always @(negedge clk_50MHz)
    begin
        // nothing can have reached MEM or WB yet
        if (since_rst < 3)
            check_value("idle strobes", 32'd0, 32'({wb_en_o, mem_we_o, mem_re_o}));
        if (wb_en_o)
        begin
            if (exp_wb.size() == 0)
            begin
                errors++;
                $display("%s: writeback to r%0d that the model never made", test_name, wb_addr_o);
            end
            else
            begin
                wb_exp = exp_wb.pop_front();
                check_value("wb_addr", 32'(wb_exp[18:16]), 32'(wb_addr_o));
                check_value("wb_data", 32'(wb_exp[15:0]), 32'(wb_data_o));
            end
        end
        if (mem_we_o)
        begin
            if (exp_st.size() == 0)
            begin
                errors++;
                $display("%s: store to %0h that the model never made", test_name, mem_addr_o);
            end
            else
            begin
                st_exp = exp_st.pop_front();
                check_value("st_addr", 32'(st_exp[31:16]), 32'(mem_addr_o));
                check_value("st_data", 32'(st_exp[15:0]), 32'(mem_wdata_o));
            end
        end
    end

    // ******************************
    // programs
    // ******************************
    task automatic build_program(input int t);
        prog.delete();
        case (t)
            0:
            begin
                test_name = "arith_chain";
                prog.push_back(imm_word(`OP_LI, 3'd1, 8'h12));
                prog.push_back(imm_word(`OP_ADDIU, 3'd1, 8'hfd));
                prog.push_back(imm_word(`OP_LI, 3'd2, 8'h7f));
                prog.push_back(rr_word(`OP_RR, 3'd1, 3'd2, 3'd3, `FN_ADDU));
                prog.push_back(rr_word(`OP_RR, 3'd3, 3'd1, 3'd4, `FN_SUBU));
                prog.push_back(rr_word(`OP_RR, 3'd4, 3'd3, 3'd5, `FN_AND));
                // r7 is never written and must read zero
                prog.push_back(rr_word(`OP_RR, 3'd5, 3'd7, 3'd6, `FN_OR));
                prog.push_back(imm_word(`OP_ADDIU, 3'd6, 8'h80));
                prog.push_back(rr_word(`OP_RR, 3'd6, 3'd6, 3'd1, `FN_ADDU));
            end
            1:
            begin
                test_name = "load_use";
                prog.push_back(imm_word(`OP_LI, 3'd1, 8'h40));
                prog.push_back(imm_word(`OP_LI, 3'd2, 8'h99));
                prog.push_back(rr_word(`OP_SW, 3'd2, 3'd1, 3'd0, 2'd0));
                prog.push_back(rr_word(`OP_LW, 3'd3, 3'd1, 3'd0, 2'd0));
                prog.push_back(rr_word(`OP_RR, 3'd3, 3'd3, 3'd4, `FN_ADDU));
                prog.push_back(rr_word(`OP_LW, 3'd5, 3'd1, 3'd0, 2'd0));
                // loaded value used as the next address
                prog.push_back(rr_word(`OP_LW, 3'd6, 3'd5, 3'd0, 2'd0));
                prog.push_back(rr_word(`OP_SW, 3'd6, 3'd2, 3'd0, 2'd0));
                prog.push_back(imm_word(`OP_ADDIU, 3'd6, 8'h01));
                prog.push_back(rr_word(`OP_LW, 3'd7, 3'd2, 3'd0, 2'd0));
            end
            2:
            begin
                test_name = "branches";
                prog.push_back(imm_word(`OP_LI, 3'd1, 8'h00));
                prog.push_back(imm_word(`OP_BEQZ, 3'd1, 8'h02));
                // store sits in ID while the branch resolves
                prog.push_back(rr_word(`OP_SW, 3'd1, 3'd1, 3'd0, 2'd0));
                prog.push_back(imm_word(`OP_LI, 3'd3, 8'h22));
                prog.push_back(imm_word(`OP_LI, 3'd4, 8'h03));
                // loop body at 5 runs three times
                prog.push_back(imm_word(`OP_ADDIU, 3'd4, 8'hff));
                prog.push_back(imm_word(`OP_ADDIU, 3'd5, 8'h05));
                prog.push_back(imm_word(`OP_BEQZ, 3'd4, 8'h01));
                prog.push_back(imm_word(`OP_B, 3'd0, 8'hfc));
                prog.push_back(rr_word(`OP_SW, 3'd5, 3'd1, 3'd0, 2'd0));
                prog.push_back(imm_word(`OP_BEQZ, 3'd5, 8'h01));
                prog.push_back(imm_word(`OP_B, 3'd0, 8'h01));
                prog.push_back(imm_word(`OP_LI, 3'd6, 8'h33));
                prog.push_back(imm_word(`OP_LI, 3'd7, 8'h44));
            end
            default:
            begin
                test_name = "random_blocks";
                for (int k = 0; k < 48; k++)
                begin
                    case ($urandom_range(2, 0))
                        0: prog.push_back(imm_word(`OP_LI, 3'($urandom_range(7, 0)),
                                                   8'($urandom)));
                        1: prog.push_back(imm_word(`OP_ADDIU, 3'($urandom_range(7, 0)),
                                                   8'($urandom)));
                        default: prog.push_back(rr_word(`OP_RR, 3'($urandom_range(7, 0)),
                                                        3'($urandom_range(7, 0)),
                                                        3'($urandom_range(7, 0)),
                                                        2'($urandom_range(3, 0))));
                    endcase
                end
            end
        endcase
        prog.push_back(imm_word(`OP_B, 3'd0, 8'hff));
    endtask

    task automatic run_test();
        int steps;
        int limit;
        int cyc;
        @(negedge clk_50MHz);
        rst = 1'b0;
        @(negedge clk_50MHz);
        for (int a = 0; a < 256; a++)
            imem[a] = (a < prog.size()) ? prog[a] : NOP_WORD;
        steps = run_model();
        repeat (4) @(negedge clk_50MHz);
        rst   = 1'b1;
        limit = 10 * steps;
        cyc   = 0;
        while ((exp_wb.size() != 0 || exp_st.size() != 0) && cyc < limit)
        begin
            @(posedge clk_50MHz);
            cyc++;
        end
        if (exp_wb.size() != 0 || exp_st.size() != 0)
        begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: %s still waits for %0d writebacks and %0d stores after %0d cycles",
                     test_name, exp_wb.size(), exp_st.size(), cyc);
        end
        else
            // stray writebacks from squashed paths land here
            repeat (16) @(posedge clk_50MHz);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    initial
    begin
        rst         = 1'b0;
        inst_i      = '0;
        mem_rdata_i = '0;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        void'($urandom(32'hd8c72674));
        for (int t = 0; t < 4 && !timed_out; t++)
        begin
            build_program(t);
            run_test();
        end
        finish_run();
    end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_top
(
    input  logic                clk_50MHz_i,
    input  logic                rst_i,
    // instruction port
    output logic [`XLEN-1:0]    inst_addr_o,
    input  logic [`XLEN-1:0]    inst_i,
    // data port
    output logic [`XLEN-1:0]    mem_addr_o,
    output logic [`XLEN-1:0]    mem_wdata_o,
    output logic                mem_we_o,
    output logic                mem_re_o,
    input  logic [`XLEN-1:0]    mem_rdata_i,
    // retired register writes
    output logic                wb_en_o,
    output logic [`REG_AW-1:0]  wb_addr_o,
    output logic [`XLEN-1:0]    wb_data_o
);

    import cpu_pkg::*;

    inst_u              if_inst;
    logic [`XLEN-1:0]   if_pc;
    logic               stall;
    logic [`REG_AW-1:0] rd_addr_a;
    logic [`REG_AW-1:0] rd_addr_b;
    logic [`XLEN-1:0]   rdata_a;
    logic [`XLEN-1:0]   rdata_b;
    logic               ex_load;
    logic [`REG_AW-1:0] ex_dest;
    logic               branch_taken;
    logic [`XLEN-1:0]   branch_target;
    logic               em_wb_en;
    logic [`REG_AW-1:0] em_wb_addr;
    logic [`XLEN-1:0]   em_alu;

    cpu_ctrl_if ctrl_bus ();

    // ******************************
    // front end
    // ******************************
    cpu_fetch u_fetch
    (
        .clk_50MHz_i     (clk_50MHz_i),
        .rst_i           (rst_i),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .inst_i          (inst_i),
        .inst_addr_o     (inst_addr_o),
        .if_inst_o       (if_inst),
        .if_pc_o         (if_pc)
    );

    cpu_control u_control
    (
        .clk_50MHz_i    (clk_50MHz_i),
        .rst_i          (rst_i),
        .if_inst_i      (if_inst),
        .if_pc_i        (if_pc),
        .ex_load_i      (ex_load),
        .ex_dest_i      (ex_dest),
        .branch_taken_i (branch_taken),
        .rd_addr_a_o    (rd_addr_a),
        .rd_addr_b_o    (rd_addr_b),
        .stall_o        (stall),
        .ctrl           (ctrl_bus)
    );

    cpu_regfile u_regfile
    (
        .clk_50MHz_i (clk_50MHz_i),
        .rst_i       (rst_i),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rdata_a_o   (rdata_a),
        .rdata_b_o   (rdata_b),
        .wb_en_i     (wb_en_o),
        .wb_addr_i   (wb_addr_o),
        .wb_data_i   (wb_data_o)
    );

    // ******************************
    // back end
    // ******************************
    cpu_execute u_execute
    (
        .clk_50MHz_i     (clk_50MHz_i),
        .rst_i           (rst_i),
        .ctrl            (ctrl_bus),
        .rdata_a_i       (rdata_a),
        .rdata_b_i       (rdata_b),
        .wb_en_i         (wb_en_o),
        .wb_addr_i       (wb_addr_o),
        .wb_data_i       (wb_data_o),
        .ex_load_o       (ex_load),
        .ex_dest_o       (ex_dest),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .mem_addr_o      (mem_addr_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_we_o        (mem_we_o),
        .mem_re_o        (mem_re_o),
        .em_wb_en_o      (em_wb_en),
        .em_wb_addr_o    (em_wb_addr),
        .em_alu_o        (em_alu)
    );

    cpu_writeback u_writeback
    (
        .clk_50MHz_i  (clk_50MHz_i),
        .rst_i        (rst_i),
        .em_wb_en_i   (em_wb_en),
        .em_wb_addr_i (em_wb_addr),
        .em_alu_i     (em_alu),
        .mem_re_i     (mem_re_o),
        .mem_rdata_i  (mem_rdata_i),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

// ==== design/cpu_writeback.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_writeback
(
    input  logic                clk_50MHz_i,
    input  logic                rst_i,
    input  logic                em_wb_en_i,
    input  logic [`REG_AW-1:0]  em_wb_addr_i,
    input  logic [`XLEN-1:0]    em_alu_i,
    input  logic                mem_re_i,
    input  logic [`XLEN-1:0]    mem_rdata_i,
    output logic                wb_en_o,
    output logic [`REG_AW-1:0]  wb_addr_o,
    output logic [`XLEN-1:0]    wb_data_o
);

    logic               mw_load_q;
    logic [`XLEN-1:0]   mw_alu_q;
    logic [`XLEN-1:0]   mw_rdata_q;

    // MEM/WB strobes
    always_ff @(posedge clk_50MHz_i or negedge rst_i)
    begin
        if (!rst_i)
        begin
            wb_en_o   <= 1'b0;
            mw_load_q <= 1'b0;
        end
        else
        begin
            wb_en_o   <= em_wb_en_i;
            mw_load_q <= mem_re_i;
        end
    end

    always_ff @(posedge clk_50MHz_i)
    begin
        wb_addr_o  <= em_wb_addr_i;
        mw_alu_q   <= em_alu_i;
        mw_rdata_q <= mem_rdata_i;
    end

    // loaded word for LW, alu result otherwise
    assign wb_data_o = mw_load_q ? mw_rdata_q : mw_alu_q;

    assert property (@(posedge clk_50MHz_i) disable iff (!rst_i)
        wb_en_o |-> !$isunknown(wb_addr_o));

endmodule

// ==== design/cpu_execute.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_execute
(
    input  logic                clk_50MHz_i,
    input  logic                rst_i,
    cpu_ctrl_if.exe             ctrl,
    input  logic [`XLEN-1:0]    rdata_a_i,
    input  logic [`XLEN-1:0]    rdata_b_i,
    input  logic                wb_en_i,
    input  logic [`REG_AW-1:0]  wb_addr_i,
    input  logic [`XLEN-1:0]    wb_data_i,
    output logic                ex_load_o,
    output logic [`REG_AW-1:0]  ex_dest_o,
    output logic                branch_taken_o,
    output logic [`XLEN-1:0]    branch_target_o,
    output logic [`XLEN-1:0]    mem_addr_o,
    output logic [`XLEN-1:0]    mem_wdata_o,
    output logic                mem_we_o,
    output logic                mem_re_o,
    output logic                em_wb_en_o,
    output logic [`REG_AW-1:0]  em_wb_addr_o,
    output logic [`XLEN-1:0]    em_alu_o
);

    import cpu_pkg::*;

    // ID/EX strobes
    logic               ie_wb_en_q;
    logic               ie_mem_re_q;
    logic               ie_mem_we_q;
    logic               ie_is_beqz_q;
    logic               ie_is_b_q;
    // ID/EX payload
    logic [`ALU_W-1:0]  ie_alu_op_q;
    logic               ie_use_imm_q;
    logic [`XLEN-1:0]   ie_imm_q;
    logic [`REG_AW-1:0] ie_wb_addr_q;
    logic [`XLEN-1:0]   ie_pc_q;
    inst_u              ie_inst_q;
    logic [`XLEN-1:0]   ie_rdata_a_q;
    logic [`XLEN-1:0]   ie_rdata_b_q;

    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b_reg;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   alu_y;

    // ******************************
    // ID/EX register
    // ******************************
    always_ff @(posedge clk_50MHz_i or negedge rst_i)
    begin
        if (!rst_i)
        begin
            ie_wb_en_q   <= 1'b0;
            ie_mem_re_q  <= 1'b0;
            ie_mem_we_q  <= 1'b0;
            ie_is_beqz_q <= 1'b0;
            ie_is_b_q    <= 1'b0;
        end
        else
        begin
            ie_wb_en_q   <= ctrl.wb_en;
            ie_mem_re_q  <= ctrl.mem_re;
            ie_mem_we_q  <= ctrl.mem_we;
            ie_is_beqz_q <= ctrl.is_beqz;
            ie_is_b_q    <= ctrl.is_b;
        end
    end

    always_ff @(posedge clk_50MHz_i)
    begin
        ie_alu_op_q  <= ctrl.alu_op;
        ie_use_imm_q <= ctrl.use_imm;
        ie_imm_q     <= ctrl.imm;
        ie_wb_addr_q <= ctrl.wb_addr;
        ie_pc_q      <= ctrl.pc;
        ie_inst_q    <= ctrl.inst;
        ie_rdata_a_q <= rdata_a_i;
        ie_rdata_b_q <= rdata_b_i;
    end

    // EX/MEM first unless it is a load, then MEM/WB, then regfile
    function automatic logic [`XLEN-1:0] forward
    (
        input logic [`REG_AW-1:0] src,
        input logic [`XLEN-1:0]   rf_data
    );
        if (em_wb_en_o && !mem_re_o && em_wb_addr_o == src)
            return em_alu_o;
        else if (wb_en_i && wb_addr_i == src)
            return wb_data_i;
        else
            return rf_data;
    endfunction

    always_comb
    begin
        op_a     = forward(ie_inst_q.r.rx, ie_rdata_a_q);
        op_b_reg = forward(ie_inst_q.r.ry, ie_rdata_b_q);
    end

    assign op_b = ie_use_imm_q ? ie_imm_q : op_b_reg;

    always_comb
    begin
        case (ie_alu_op_q)
            `ALU_SUB:   alu_y = op_a - op_b;
            `ALU_AND:   alu_y = op_a & op_b;
            `ALU_OR:    alu_y = op_a | op_b;
            `ALU_PASSB: alu_y = op_b;
            default:    alu_y = op_a + op_b;
        endcase
    end

    // branch resolves here, target is pc+1+imm
    assign branch_taken_o  = ie_is_b_q || (ie_is_beqz_q && op_a == '0);
    assign branch_target_o = ie_pc_q + 1'b1 + ie_imm_q;
    assign ex_load_o       = ie_mem_re_q;
    assign ex_dest_o       = ie_wb_addr_q;

    // ******************************
    // EX/MEM register
    // ******************************
    always_ff @(posedge clk_50MHz_i or negedge rst_i)
    begin
        if (!rst_i)
        begin
            em_wb_en_o <= 1'b0;
            mem_re_o   <= 1'b0;
            mem_we_o   <= 1'b0;
        end
        else
        begin
            em_wb_en_o <= ie_wb_en_q;
            mem_re_o   <= ie_mem_re_q;
            mem_we_o   <= ie_mem_we_q;
        end
    end

    always_ff @(posedge clk_50MHz_i)
    begin
        em_wb_addr_o <= ie_wb_addr_q;
        em_alu_o     <= alu_y;
        mem_addr_o   <= op_b_reg;
        mem_wdata_o  <= op_a;
    end

    // decode never yields a load that also stores
    assert property (@(posedge clk_50MHz_i) disable iff (!rst_i)
        !(mem_we_o && mem_re_o));

endmodule

// ==== design/cpu_regfile.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_regfile
(
    input  logic                clk_50MHz_i,
    input  logic                rst_i,
    input  logic [`REG_AW-1:0]  rd_addr_a_i,
    input  logic [`REG_AW-1:0]  rd_addr_b_i,
    output logic [`XLEN-1:0]    rdata_a_o,
    output logic [`XLEN-1:0]    rdata_b_o,
    input  logic                wb_en_i,
    input  logic [`REG_AW-1:0]  wb_addr_i,
    input  logic [`XLEN-1:0]    wb_data_i
);

    logic [`XLEN-1:0] regs [`NREG];

    always_ff @(posedge clk_50MHz_i or negedge rst_i)
    begin
        if (!rst_i)
        begin
            for (int i = 0; i < `NREG; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_en_i)
        begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // write in the same cycle wins over the stored value
    assign rdata_a_o = (wb_en_i && wb_addr_i == rd_addr_a_i) ? wb_data_i : regs[rd_addr_a_i];
    assign rdata_b_o = (wb_en_i && wb_addr_i == rd_addr_b_i) ? wb_data_i : regs[rd_addr_b_i];

endmodule

// ==== design/cpu_fetch.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_fetch
(
    input  logic                clk_50MHz_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                branch_taken_i,
    input  logic [`XLEN-1:0]    branch_target_i,
    input  logic [`XLEN-1:0]    inst_i,
    output logic [`XLEN-1:0]    inst_addr_o,
    output cpu_pkg::inst_u      if_inst_o,
    output logic [`XLEN-1:0]    if_pc_o
);

    localparam logic [`XLEN-1:0] NOP_WORD = {`OP_NOP, {(`XLEN-`OP_W){1'b0}}};

    logic [`XLEN-1:0] pc_q;

    assign inst_addr_o = pc_q;

    // pc and IF/ID
    always_ff @(posedge clk_50MHz_i or negedge rst_i)
    begin
        if (!rst_i)
        begin
            pc_q      <= '0;
            if_inst_o <= NOP_WORD;
            if_pc_o   <= '0;
        end
        else if (branch_taken_i)
        begin
            pc_q      <= branch_target_i;
            if_inst_o <= NOP_WORD;
        end
        else if (!stall_i)
        begin
            pc_q      <= pc_q + 1'b1;
            if_inst_o <= inst_i;
            if_pc_o   <= pc_q;
        end
    end

    // load-use stall from control holds the fetch address
    assert property (@(posedge clk_50MHz_i) disable iff (!rst_i)
        stall_i |=> $stable(pc_q));

endmodule

// ==== design/cpu_control.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_control
(
    input  logic                clk_50MHz_i,
    input  logic                rst_i,
    input  cpu_pkg::inst_u      if_inst_i,
    input  logic [`XLEN-1:0]    if_pc_i,
    input  logic                ex_load_i,
    input  logic [`REG_AW-1:0]  ex_dest_i,
    input  logic                branch_taken_i,
    output logic [`REG_AW-1:0]  rd_addr_a_o,
    output logic [`REG_AW-1:0]  rd_addr_b_o,
    output logic                stall_o,
    cpu_ctrl_if.ctrl            ctrl
);

    logic [`OP_W-1:0]   opcode;
    logic               reads_rx;
    logic               reads_ry;
    logic               bubble;
    logic [`XLEN-1:0]   imm_sext;
    logic [`XLEN-1:0]   imm_zext;

    assign opcode      = if_inst_i.r.opcode;
    assign rd_addr_a_o = if_inst_i.r.rx;
    assign rd_addr_b_o = if_inst_i.r.ry;
    assign imm_sext    = {{(`XLEN-`IMM_W){if_inst_i.i.imm8[`IMM_W-1]}}, if_inst_i.i.imm8};
    assign imm_zext    = {{(`XLEN-`IMM_W){1'b0}}, if_inst_i.i.imm8};

    // ******************************
    // load-use hazard
    // ******************************
    // only sources the opcode really reads
    always_comb
    begin
        reads_rx = 1'b0;
        reads_ry = 1'b0;
        case (opcode)
            `OP_ADDIU, `OP_BEQZ: reads_rx = 1'b1;
            `OP_LW:              reads_ry = 1'b1;
            `OP_RR, `OP_SW:
            begin
                reads_rx = 1'b1;
                reads_ry = 1'b1;
            end
            default: ;
        endcase
    end

    assign stall_o = ex_load_i && ((reads_rx && ex_dest_i == if_inst_i.r.rx) ||
                                   (reads_ry && ex_dest_i == if_inst_i.r.ry));
    assign bubble  = stall_o || branch_taken_i;

    // ******************************
    // decode
    // ******************************
    always_comb
    begin
        ctrl.alu_op  = `ALU_ADD;
        ctrl.use_imm = 1'b0;
        ctrl.imm     = imm_sext;
        ctrl.wb_en   = 1'b0;
        ctrl.wb_addr = if_inst_i.r.rx;
        ctrl.mem_re  = 1'b0;
        ctrl.mem_we  = 1'b0;
        ctrl.is_beqz = 1'b0;
        ctrl.is_b    = 1'b0;
        ctrl.pc      = if_pc_i;
        ctrl.inst    = if_inst_i;
        case (opcode)
            `OP_LI:
            begin
                ctrl.alu_op  = `ALU_PASSB;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_zext;
                ctrl.wb_en   = 1'b1;
            end
            `OP_ADDIU:
            begin
                ctrl.use_imm = 1'b1;
                ctrl.wb_en   = 1'b1;
            end
            `OP_RR:
            begin
                ctrl.wb_en   = 1'b1;
                ctrl.wb_addr = if_inst_i.r.rz;
                case (if_inst_i.r.funct)
                    `FN_SUBU: ctrl.alu_op = `ALU_SUB;
                    `FN_AND:  ctrl.alu_op = `ALU_AND;
                    `FN_OR:   ctrl.alu_op = `ALU_OR;
                    default:  ctrl.alu_op = `ALU_ADD;
                endcase
            end
            `OP_LW:
            begin
                ctrl.wb_en  = 1'b1;
                ctrl.mem_re = 1'b1;
            end
            `OP_SW:   ctrl.mem_we  = 1'b1;
            `OP_BEQZ: ctrl.is_beqz = 1'b1;
            `OP_B:    ctrl.is_b    = 1'b1;
            // NOP and undefined opcodes fall through
            default: ;
        endcase

        // squash on stall or taken branch
        if (bubble)
        begin
            ctrl.wb_en   = 1'b0;
            ctrl.mem_re  = 1'b0;
            ctrl.mem_we  = 1'b0;
            ctrl.is_beqz = 1'b0;
            ctrl.is_b    = 1'b0;
        end
    end

    // a load in EX is never a branch, so no double squash
    assert property (@(posedge clk_50MHz_i) disable iff (!rst_i)
        !(stall_o && branch_taken_i));

endmodule

// ==== design/cpu_ctrl_if.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

interface cpu_ctrl_if;

    import cpu_pkg::*;

    // decoded bundle from ID to EX
    logic [`ALU_W-1:0]  alu_op;
    logic               use_imm;
    logic [`XLEN-1:0]   imm;
    logic               wb_en;
    logic [`REG_AW-1:0] wb_addr;
    logic               mem_re;
    logic               mem_we;
    logic               is_beqz;
    logic               is_b;
    logic [`XLEN-1:0]   pc;
    // source register fields for forwarding
    inst_u              inst;

    modport ctrl
    (
        output alu_op, use_imm, imm, wb_en, wb_addr, mem_re, mem_we,
        output is_beqz, is_b, pc, inst
    );

    modport exe
    (
        input alu_op, use_imm, imm, wb_en, wb_addr, mem_re, mem_we,
        input is_beqz, is_b, pc, inst
    );

endinterface

// ==== design/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

    // one instruction word, two decodings
    // register view for OP_RR, LW and SW
    // immediate view for LI, ADDIU and the branches
    typedef union packed
    {
        struct packed
        {
            logic [`OP_W-1:0]   opcode;
            logic [`REG_AW-1:0] rx;
            logic [`REG_AW-1:0] ry;
            logic [`REG_AW-1:0] rz;
            logic [`FN_W-1:0]   funct;
        } r;
        struct packed
        {
            logic [`OP_W-1:0]   opcode;
            logic [`REG_AW-1:0] rx;
            logic [`IMM_W-1:0]  imm8;
        } i;
    } inst_u;

endpackage

// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ******************************
// widths
// ******************************
`define XLEN        16
`define NREG        8
`define REG_AW      3
`define OP_W        5
`define FN_W        2
`define IMM_W       8
`define ALU_W       3

// ******************************
// opcodes, top five bits
// ******************************
`define OP_NOP      5'b00001
`define OP_B        5'b00010
`define OP_BEQZ     5'b00100
`define OP_ADDIU    5'b01001
`define OP_LI       5'b01101
`define OP_LW       5'b10011
`define OP_SW       5'b11011
// all register-register ops, funct selects
`define OP_RR       5'b11100

// funct field of an OP_RR word
`define FN_ADDU     2'b01
`define FN_SUBU     2'b11
`define FN_AND      2'b00
`define FN_OR       2'b10

// alu operation codes
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_PASSB   3'd4

`endif
